// File: Makefile
VERILATOR ?= verilator
TOP       ?= pipeline_tb
FILE_LIST ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(wildcard common/*.sv common/*.svh core/*.sv verilog/*.sv tb/*.sv)

.PHONY: all compile run clean

all: run

compile: $(BUILD_DIR)/V$(TOP)

$(BUILD_DIR)/V$(TOP): $(FILE_LIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: common/rv_config.svh
// Build-time sizes for the RV32I core.
// Instruction memory depth is 2**RV_IMEM_AW words; the PC wraps at the end.
// RV_REG_COUNT must stay 32 to match the 5-bit register fields.

`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

// instruction memory address width for 64 words
`define RV_IMEM_AW 6

// architectural registers with x0 hardwired to zero
`define RV_REG_COUNT 32

`endif

// File: common/rv_pkg.sv
// Types shared by the pipeline stages of the RV32I core.
// Only OP_REG and OP_IMM opcodes are named; all others decode as no-ops.

`default_nettype none

package rv_pkg;

  typedef enum logic [6:0] {
    OP_REG = 7'b0110011,
    OP_IMM = 7'b0010011
  } opcode_type;

  typedef enum logic [2:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLT
  } alu_op_type;

  // I-type immediate is {funct7, rs2}
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } instruction_type;

  typedef struct packed {
    logic       reg_write;
    logic       use_imm;
    alu_op_type alu_op;
  } control_type;

  typedef struct packed {
    control_type control;
    logic [31:0] data1;
    logic [31:0] data2;
    logic [31:0] imm;
    logic [4:0]  rs1;
    logic [4:0]  rs2;
    logic [4:0]  rd;
  } id_ex_type;

  // write-back bus
  typedef struct packed {
    logic        reg_write;
    logic [4:0]  rd;
    logic [31:0] data;
  } wb_type;

endpackage

`default_nettype wire

// File: core/decode_unit.sv
// Decode stage with the register file and the ID/EX register.
// Unsupported funct3/funct7 combinations and other opcodes retire as no-ops.
// A write on the wb bus is visible to a read in the same cycle.

`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module decode_unit (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    valid,
  input  wire rv_pkg::instruction_type instruction,
  input  wire rv_pkg::wb_type          wb,
  output rv_pkg::id_ex_type            id_ex
);

  logic [31:0]         regs [0:`RV_REG_COUNT-1];
  rv_pkg::opcode_type  opcode;
  rv_pkg::control_type control;
  logic                funct_ok;
  logic [31:0]         imm;
  logic [31:0]         data1;
  logic [31:0]         data2;

  assign opcode = rv_pkg::opcode_type'(instruction.opcode);
  assign imm    = {{20{instruction.funct7[6]}}, instruction.funct7, instruction.rs2};

  always_comb begin
    control  = '0;
    funct_ok = 1'b1;
    case (instruction.funct3)
      3'b000:  control.alu_op = rv_pkg::ALU_ADD;
      3'b010:  control.alu_op = rv_pkg::ALU_SLT;
      3'b100:  control.alu_op = rv_pkg::ALU_XOR;
      3'b110:  control.alu_op = rv_pkg::ALU_OR;
      3'b111:  control.alu_op = rv_pkg::ALU_AND;
      default: funct_ok = 1'b0;
    endcase
    case (opcode)
      rv_pkg::OP_REG: begin
        // funct7 is 0, or 0100000 for SUB only
        control.reg_write = valid && funct_ok &&
                            ((instruction.funct7 == 7'b0000000) ||
                             (instruction.funct7 == 7'b0100000 && instruction.funct3 == 3'b000));
        if (instruction.funct7[5]) begin
          control.alu_op = rv_pkg::ALU_SUB;
        end
      end
      rv_pkg::OP_IMM: begin
        control.reg_write = valid && funct_ok;
        control.use_imm   = 1'b1;
      end
      default: ;
    endcase
  end

  function automatic logic [31:0] read_reg(input logic [4:0] addr);
    if (addr == 5'd0) begin
      return '0;
    end
    // write-through from the wb bus
    if (wb.reg_write && wb.rd == addr) begin
      return wb.data;
    end
    return regs[addr];
  endfunction

  assign data1 = read_reg(instruction.rs1);
  assign data2 = read_reg(instruction.rs2);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        regs[i] <= '0;
      end
    end else if (wb.reg_write && wb.rd != 5'd0) begin
      regs[wb.rd] <= wb.data;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex <= '0;
    end else begin
      id_ex.control <= control;
      id_ex.data1   <= data1;
      id_ex.data2   <= data2;
      id_ex.imm     <= imm;
      id_ex.rs1     <= instruction.rs1;
      id_ex.rs2     <= instruction.rs2;
      id_ex.rd      <= instruction.rd;
    end
  end

endmodule

`default_nettype wire

// File: core/execute_unit.sv
// Execute stage with operand forwarding and the EX/WB register.
// Only the previous instruction is forwarded here; older results come
// through the register file write-through in decode.

`timescale 1ns/1ps
`default_nettype none

module execute_unit (
  input  wire logic              clk,
  input  wire logic              rst,
  input  wire rv_pkg::id_ex_type id_ex,
  output rv_pkg::wb_type         wb
);

  logic [31:0] op_a;
  logic [31:0] rs2_value;
  logic [31:0] op_b;
  logic [31:0] result;

  always_comb begin
    op_a      = id_ex.data1;
    rs2_value = id_ex.data2;
    if (wb.reg_write && wb.rd != 5'd0 && wb.rd == id_ex.rs1) begin
      op_a = wb.data;
    end
    if (wb.reg_write && wb.rd != 5'd0 && wb.rd == id_ex.rs2) begin
      rs2_value = wb.data;
    end
  end

  assign op_b = id_ex.control.use_imm ? id_ex.imm : rs2_value;

  always_comb begin
    case (id_ex.control.alu_op)
      rv_pkg::ALU_ADD: result = op_a + op_b;
      rv_pkg::ALU_SUB: result = op_a - op_b;
      rv_pkg::ALU_AND: result = op_a & op_b;
      rv_pkg::ALU_OR:  result = op_a | op_b;
      rv_pkg::ALU_XOR: result = op_a ^ op_b;
      // signed compare
      rv_pkg::ALU_SLT: result = {31'b0, $signed(op_a) < $signed(op_b)};
      default:         result = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wb <= '0;
    end else begin
      wb.reg_write <= id_ex.control.reg_write;
      wb.rd        <= id_ex.rd;
      wb.data      <= result;
    end
  end

endmodule

`default_nettype wire

// File: core/fetch_unit.sv
// Instruction memory and program counter.
// The load port writes memory only while run is low; loads during run are ignored.
// PC is held at 0 while run is low and wraps at the end of memory.

`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module fetch_unit (
  input  wire logic                    clk,
  input  wire logic                    rst,
  input  wire logic                    run,
  input  wire logic                    load_en,
  input  wire logic [`RV_IMEM_AW-1:0]  load_addr,
  input  wire logic [31:0]             load_data,
  output rv_pkg::instruction_type      instruction,
  output logic                         valid
);

  rv_pkg::instruction_type imem [0:(1 << `RV_IMEM_AW)-1];
  logic [`RV_IMEM_AW-1:0]  pc;

  always_ff @(posedge clk) begin
    if (load_en && !run) begin
      imem[load_addr] <= rv_pkg::instruction_type'(load_data);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc          <= '0;
      valid       <= 1'b0;
      instruction <= '0;
    end else if (run) begin
      instruction <= imem[pc];
      valid       <= 1'b1;
      // natural wrap at the top word
      pc          <= pc + 1'b1;
    end else begin
      pc    <= '0;
      valid <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: tb/pipeline_assert.sv
// Concurrent checks bound into pipeline_top.
// The reset check looks only at the first cycle after rst falls.

`timescale 1ns/1ps
`default_nettype none

module pipeline_assert (
  input wire logic        clk,
  input wire logic        rst,
  input wire logic        run,
  input wire logic        load_en,
  input wire logic        valid,
  input wire logic        id_ex_reg_write,
  input wire logic [31:0] capture_x0
);

  int failures = 0;

  x0_stays_zero: assert property (@(posedge clk) disable iff (rst) capture_x0 == 32'd0)
    else begin
      failures++;
      $error("capture entry 0 is not zero");
    end

  // valid is registered, so it follows run one edge later
  idle_when_stopped: assert property (@(posedge clk) disable iff (rst) !$past(run) |-> !valid)
    else begin
      failures++;
      $error("valid high after a cycle with run low");
    end

  no_load_while_running: assert property (@(posedge clk) disable iff (rst) !(load_en && run))
    else begin
      failures++;
      $error("load_en high while run is high");
    end

  clean_after_reset: assert property (@(posedge clk) $fell(rst) |-> !id_ex_reg_write)
    else begin
      failures++;
      $error("id_ex reg_write set right after reset");
    end

endmodule

bind pipeline_top pipeline_assert assert0 (
  .clk             (clk),
  .rst             (rst),
  .run             (run),
  .load_en         (load_en),
  .valid           (if_valid),
  .id_ex_reg_write (id_ex.control.reg_write),
  .capture_x0      (capture0.shadow[0])
);

`default_nettype wire

// File: tb/pipeline_tb.sv
// Runs random ALU programs on pipeline_top and checks them against an ISA model.
// Programs stay under 60 words, so the PC never wraps during a run.
// Register state carries over from one program to the next, as in the DUT.

`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module pipeline_tb;

  localparam int imem_words = 1 << `RV_IMEM_AW;
  localparam logic [2:0] funct3_table [5] = '{3'b000, 3'b010, 3'b100, 3'b110, 3'b111};
  localparam logic [4:0] extreme_regs [4] = '{5'd0, 5'd2, 5'd3, 5'd4};

  logic                   clk = 1'b0;
  logic                   rst;
  logic                   run;
  logic                   load_en;
  logic [`RV_IMEM_AW-1:0] load_addr;
  logic [31:0]            load_data;
  logic [4:0]             led_address;
  logic                   led_upper;
  logic [15:0]            led;

  logic [31:0]             model_regs [0:31];
  rv_pkg::instruction_type prog [$];

  always #2 clk = ~clk;

  pipeline_top dut0 (.*);

  function automatic rv_pkg::instruction_type encode(input logic [6:0] f7,
      input logic [4:0] rs2, input logic [4:0] rs1, input logic [2:0] f3,
      input logic [4:0] rd, input logic [6:0] op);
    return {f7, rs2, rs1, f3, rd, op};
  endfunction

  function automatic logic [4:0] low_reg();
    return 5'($urandom_range(7));
  endfunction

  // picks 0-4 register ops, 5-9 immediate ops, 10 SUB
  function automatic rv_pkg::instruction_type random_alu(input logic [4:0] rd,
      input logic [4:0] rs1, input logic [4:0] rs2);
    int unsigned pick;
    logic [2:0]  f3;
    logic [11:0] imm;
    pick = $urandom_range(10);
    imm  = 12'($urandom);
    f3   = funct3_table[3'(pick % 5)];
    if (pick == 10) begin
      return encode(7'b0100000, rs2, rs1, 3'b000, rd, 7'b0110011);
    end
    if (pick >= 5) begin
      return encode(imm[11:5], imm[4:0], rs1, f3, rd, 7'b0010011);
    end
    return encode(7'b0000000, rs2, rs1, f3, rd, 7'b0110011);
  endfunction

  function automatic void model_step(input rv_pkg::instruction_type ins);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] r;
    logic        ok;
    a  = model_regs[ins.rs1];
    b  = model_regs[ins.rs2];
    r  = '0;
    ok = (ins.opcode == 7'b0110011 && ins.funct7 == 7'b0000000) || ins.opcode == 7'b0010011;
    if (ins.opcode == 7'b0010011) begin
      b = {{20{ins.funct7[6]}}, ins.funct7, ins.rs2};
    end
    case (ins.funct3)
      3'b000:  r = a + b;
      3'b010:  r = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
      3'b100:  r = a ^ b;
      3'b110:  r = a | b;
      3'b111:  r = a & b;
      default: ok = 1'b0;
    endcase
    if (ins.opcode == 7'b0110011 && ins.funct7 == 7'b0100000 && ins.funct3 == 3'b000) begin
      r  = a - b;
      ok = 1'b1;
    end
    if (ok && ins.rd != 5'd0) begin
      model_regs[ins.rd] = r;
    end
  endfunction

  task automatic check_led(input logic [15:0] expected, input int index, input logic upper);
    if (led !== expected) begin
      $display("[ERROR] led x%0d upper=%0d: expected %h, actual %h",
               index, upper, expected, led);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic check_instruction(input rv_pkg::instruction_type expected,
      input logic [`RV_IMEM_AW-1:0] addr);
    rv_pkg::instruction_type actual;
    actual = dut0.fetch0.imem[addr];
    if (actual !== expected) begin
      $display("[ERROR] imem[%0d]: expected %h, actual %h", addr, expected, actual);
      $display("Test failed");
      $fatal(1);
    end
  endtask

  task automatic load_memory();
    while (prog.size() < imem_words) begin
      prog.push_back('0);
    end
    for (int i = 0; i < imem_words; i++) begin
      @(posedge clk);
      load_en   <= 1'b1;
      load_addr <= i[`RV_IMEM_AW-1:0];
      load_data <= prog[i];
    end
    @(posedge clk);
    load_en <= 1'b0;
  endtask

  task automatic wait_pipeline_idle();
    int cycles;
    cycles = 0;
    @(negedge clk);
    while (dut0.if_valid || dut0.id_ex.control.reg_write || dut0.wb.reg_write) begin
      if (cycles == 20) begin
        $display("timeout: pipeline still busy 20 cycles after run went low");
        $display("Test failed");
        $fatal(1);
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic check_registers();
    for (int r = 0; r < 32; r++) begin
      for (int h = 0; h < 2; h++) begin
        @(posedge clk);
        led_address <= r[4:0];
        led_upper   <= h[0];
        @(negedge clk);
        check_led(h[0] ? model_regs[r[4:0]][31:16] : model_regs[r[4:0]][15:0], r, h[0]);
      end
    end
  endtask

  task automatic run_program();
    int len;
    len = prog.size();
    foreach (prog[i]) begin
      model_step(prog[i]);
    end
    load_memory();
    @(posedge clk);
    run <= 1'b1;
    // last word retires at run edge len+2
    repeat (len + 4) @(posedge clk);
    run <= 1'b0;
    wait_pipeline_idle();
    check_registers();
    prog.delete();
  endtask

  initial begin
    logic [4:0] rd;
    logic [4:0] prev1;
    logic [4:0] prev2;
    logic       sub;
    void'($urandom(4007));
    rst         = 1'b1;
    run         = 1'b0;
    load_en     = 1'b0;
    load_addr   = '0;
    load_data   = '0;
    led_address = '0;
    led_upper   = 1'b0;
    foreach (model_regs[i]) begin
      model_regs[i] = '0;
    end
    repeat (8) @(posedge clk);
    rst <= 1'b0;

    check_registers();

    for (int i = 0; i < imem_words; i++) begin
      prog.push_back(rv_pkg::instruction_type'($urandom));
    end
    load_memory();
    @(negedge clk);
    foreach (prog[i]) begin
      check_instruction(prog[i], i[`RV_IMEM_AW-1:0]);
    end
    prog.delete();

    repeat (2) begin
      for (int i = 0; i < 40; i++) begin
        prog.push_back(random_alu(low_reg(), low_reg(), low_reg()));
      end
      run_program();
    end

    // each instruction reads the two results just before it in random operand order
    prev1 = 5'd1;
    prev2 = 5'd2;
    for (int i = 0; i < 40; i++) begin
      rd = 5'($urandom_range(7, 1));
      if ($urandom_range(1) == 0) begin
        prog.push_back(random_alu(rd, prev1, prev2));
      end else begin
        prog.push_back(random_alu(rd, prev2, prev1));
      end
      prev2 = prev1;
      prev1 = rd;
    end
    run_program();

    for (int i = 0; i < 40; i++) begin
      case ($urandom_range(4))
        0: prog.push_back(random_alu(5'd0, low_reg(), low_reg()));
        1: prog.push_back('0);
        // branch opcode that this core does not execute
        2: prog.push_back(rv_pkg::instruction_type'({25'($urandom), 7'b1100011}));
        3: prog.push_back(encode(7'd0, 5'($urandom), low_reg(), 3'b001, low_reg(), 7'b0010011));
        default: prog.push_back(random_alu(low_reg(), low_reg(), low_reg()));
      endcase
    end
    run_program();

    // x2 doubled up to 0x80000000, then x3 = 0x7fffffff and x4 = -1
    prog.push_back(encode(7'd0, 5'd1, 5'd0, 3'b000, 5'd2, 7'b0010011));
    repeat (31) prog.push_back(encode(7'd0, 5'd2, 5'd2, 3'b000, 5'd2, 7'b0110011));
    prog.push_back(encode(7'h7f, 5'h1f, 5'd2, 3'b000, 5'd3, 7'b0010011));
    prog.push_back(encode(7'h7f, 5'h1f, 5'd0, 3'b000, 5'd4, 7'b0010011));
    prog.push_back(encode(7'h40, 5'd0, 5'd2, 3'b010, 5'd8, 7'b0010011));
    prog.push_back(encode(7'h3f, 5'h1f, 5'd3, 3'b010, 5'd9, 7'b0010011));
    for (int i = 0; i < 20; i++) begin
      sub = 1'($urandom_range(1));
      prog.push_back(encode(sub ? 7'b0100000 : 7'b0000000,
                            extreme_regs[2'($urandom_range(3))],
                            extreme_regs[2'($urandom_range(3))],
                            sub ? 3'b000 : 3'b010, 5'($urandom_range(7, 5)), 7'b0110011));
    end
    run_program();

    if (dut0.assert0.failures == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verilog.f
+incdir+common
common/rv_pkg.sv
core/fetch_unit.sv
core/decode_unit.sv
core/execute_unit.sv
verilog/register_capture.sv
verilog/pipeline_top.sv
tb/pipeline_assert.sv
tb/pipeline_tb.sv

// File: verilog/pipeline_top.sv
// Four-stage RV32I ALU core with a word load port and an LED register view.
// Load instruction memory with run low, then raise run to execute from word 0.
// No branches or loads, so the pipeline never stalls or flushes.

`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module pipeline_top (
  input  wire logic                   clk,
  input  wire logic                   rst,
  input  wire logic                   run,
  input  wire logic                   load_en,
  input  wire logic [`RV_IMEM_AW-1:0] load_addr,
  input  wire logic [31:0]            load_data,
  input  wire logic [4:0]             led_address,
  input  wire logic                   led_upper,
  output logic [15:0]                 led
);

  rv_pkg::instruction_type if_instruction;
  logic                    if_valid;
  rv_pkg::id_ex_type       id_ex;
  // shared by decode, execute and capture
  rv_pkg::wb_type          wb;

  fetch_unit fetch0 (
    .clk         (clk),
    .rst         (rst),
    .run         (run),
    .load_en     (load_en),
    .load_addr   (load_addr),
    .load_data   (load_data),
    .instruction (if_instruction),
    .valid       (if_valid)
  );

  decode_unit decode0 (
    .clk         (clk),
    .rst         (rst),
    .valid       (if_valid),
    .instruction (if_instruction),
    .wb          (wb),
    .id_ex       (id_ex)
  );

  execute_unit execute0 (
    .clk   (clk),
    .rst   (rst),
    .id_ex (id_ex),
    .wb    (wb)
  );

  register_capture capture0 (
    .clk         (clk),
    .rst         (rst),
    .wb          (wb),
    .led_address (led_address),
    .led_upper   (led_upper),
    .led         (led)
  );

endmodule

`default_nettype wire

// File: verilog/register_capture.sv
// Debug shadow of the architectural registers written from the wb bus.
// led shows one half-word of the selected register, combinationally.

`timescale 1ns/1ps
`default_nettype none

`include "rv_config.svh"

module register_capture (
  input  wire logic           clk,
  input  wire logic           rst,
  input  wire rv_pkg::wb_type wb,
  input  wire logic [4:0]     led_address,
  input  wire logic           led_upper,
  output logic [15:0]         led
);

  logic [31:0] shadow [0:`RV_REG_COUNT-1];
  logic [31:0] selected;

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `RV_REG_COUNT; i++) begin
        shadow[i] <= '0;
      end
    end else if (wb.reg_write && wb.rd != 5'd0) begin
      shadow[wb.rd] <= wb.data;
    end
  end

  assign selected = shadow[led_address];
  // upper half on led_upper
  assign led      = led_upper ? selected[31:16] : selected[15:0];

endmodule

`default_nettype wire
